// File: Makefile
TOOL      = verilator
FLAGS     = --timing --assert
TOP       = tb_top
FILE_LIST = files.f
LOG       = sim.log
FAIL_MSG  = tests failed

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILE_LIST) --top-module $(TOP)

# a crashed or aborted run counts as a failed run
sim:
	$(TOOL) --binary $(FLAGS) -f $(FILE_LIST) --top-module $(TOP) -o $(TOP)_sim
	./obj_dir/$(TOP)_sim > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: files.f
verilog/uart_cmd_pkg.sv
verilog/uart_tx_frame.sv
verilog/uart_rx_frame.sv
verilog/uart_cmd_seq.sv
verilog/uart_cmd_top.sv
verif/tb_clk_gen.sv
verif/tb_checker.sv
verif/tb_top.sv

// File: verif/tb_checker.sv
module tb_checker
  import uart_cmd_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cmd_req,
  input  logic [15:0] cmd_data,
  input  logic        cmd_ack,
  input  logic [7:0]  rsp_data,
  input  rsp_status_t rsp_status,
  input  logic        tx,
  input  logic        frame_valid,
  input  logic [7:0]  frame_byte,
  input  logic        frame_par_ok,
  input  logic        frame_stop_ok,
  input  rsp_status_t exp_status,
  input  logic [7:0]  exp_rdata,
  output int          n_value_err,
  output int          n_frame_err,
  output int          n_proto_err,
  output int          n_done
);

  cmd_t        cmd_lat;
  rsp_status_t st_lat;
  logic [7:0]  rdata_lat;
  logic        req_q;
  logic        ack_q;
  logic        in_cmd;
  int          frame_idx;

  task automatic value_err(input string msg);
    n_value_err++;
    $display("ERR %0t: %s", $time, msg);
  endtask

  task automatic proto_err(input string msg);
    n_proto_err++;
    $display("handshake or line rule broken at time %0t: %s", $time, msg);
  endtask

  task automatic check_frame();
    logic [7:0] exp_byte;
    // header first, then write data
    exp_byte = (frame_idx == 0) ? {cmd_lat.rd, cmd_lat.addr} : cmd_lat.wdata;
    if (!in_cmd) begin
      proto_err("frame on tx with no command in progress");
    end else if (frame_idx >= (cmd_lat.rd ? 1 : 2)) begin
      proto_err("more frames on tx than the command needs");
    end else if (frame_byte !== exp_byte) begin
      value_err($sformatf("frame %0d byte %02h, expected %02h", frame_idx, frame_byte,
                          exp_byte));
    end
    if (!frame_par_ok || !frame_stop_ok) begin
      n_frame_err++;
      $display("ERR %0t: frame %0d parity ok %0b, stop ok %0b", $time, frame_idx,
               frame_par_ok, frame_stop_ok);
    end
    frame_idx++;
  endtask

  task automatic check_result();
    int n_exp;
    n_exp = cmd_lat.rd ? 1 : 2;
    n_done++;
    if (!cmd_req) begin
      proto_err("cmd_ack rose while cmd_req was low");
    end
    if (frame_idx != n_exp) begin
      proto_err($sformatf("%0d frames on tx, expected %0d", frame_idx, n_exp));
    end
    if (rsp_status !== st_lat) begin
      value_err($sformatf("rsp_status %0d, expected %0d", rsp_status, st_lat));
    end else if (st_lat == st_ok && rsp_data !== rdata_lat) begin
      value_err($sformatf("rsp_data %02h, expected %02h", rsp_data, rdata_lat));
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      n_value_err = 0;
      n_frame_err = 0;
      n_proto_err = 0;
      n_done      = 0;
      req_q       = 1'b0;
      ack_q       = 1'b0;
      in_cmd      = 1'b0;
      frame_idx   = 0;
    end else begin
      if (cmd_req && !req_q) begin
        cmd_lat   = cmd_t'(cmd_data);
        st_lat    = exp_status;
        rdata_lat = exp_rdata;
        in_cmd    = 1'b1;
        frame_idx = 0;
      end
      if (frame_valid) begin
        check_frame();
      end
      if (cmd_ack && !ack_q) begin
        check_result();
      end
      if (!cmd_ack && ack_q) begin
        if (req_q) begin
          proto_err("cmd_ack dropped while cmd_req was still high");
        end
        in_cmd = 1'b0;
      end
      // line idles high outside frames
      if ((!in_cmd || cmd_ack) && !tx) begin
        proto_err("tx low between frames");
      end
      req_q = cmd_req;
      ack_q = cmd_ack;
    end
  end

endmodule

// File: verif/tb_clk_gen.sv
module tb_clk_gen #(
  parameter int period     = 40,
  parameter int rst_cycles = 10
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (rst_cycles) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// File: verif/tb_top.sv
module tb_top
  import uart_cmd_pkg::*;
();

  localparam int clks_per_bit = 8;
  localparam int rsp_timeout  = 300;

  logic        clk;
  logic        rst_n;
  logic        cmd_req;
  logic [15:0] cmd_data;
  logic        cmd_ack;
  logic [7:0]  rsp_data;
  rsp_status_t rsp_status;
  logic        tx;
  logic        rx;

  // frames decoded from tx
  logic        frame_valid;
  logic [7:0]  frame_byte;
  logic        frame_par_ok;
  logic        frame_stop_ok;

  logic [15:0] cur_cmd;
  logic [7:0]  cur_rsp;
  logic [1:0]  cur_act;
  rsp_status_t exp_status;
  logic [7:0]  exp_rdata;
  int          cmd_seq;
  event        rsp_go;

  int n_value_err;
  int n_frame_err;
  int n_proto_err;
  int n_done;
  int cycles = 0;
  int limit  = 0;
  int seed   = 54634;

  logic [15:0] vec_cmd[$];
  logic [7:0]  vec_rsp[$];
  logic [1:0]  vec_act[$];
  logic [1:0]  vec_st[$];
  logic [7:0]  vec_rdata[$];

  tb_clk_gen #(.period(40), .rst_cycles(10)) i_clk_gen (.clk(clk), .rst_n(rst_n));

  uart_cmd_top #(
    .clks_per_bit(clks_per_bit),
    .rsp_timeout (rsp_timeout)
  ) i_uart_cmd_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_req   (cmd_req),
    .cmd_data  (cmd_data),
    .cmd_ack   (cmd_ack),
    .rsp_data  (rsp_data),
    .rsp_status(rsp_status),
    .tx        (tx),
    .rx        (rx)
  );

  tb_checker i_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_req      (cmd_req),
    .cmd_data     (cmd_data),
    .cmd_ack      (cmd_ack),
    .rsp_data     (rsp_data),
    .rsp_status   (rsp_status),
    .tx           (tx),
    .frame_valid  (frame_valid),
    .frame_byte   (frame_byte),
    .frame_par_ok (frame_par_ok),
    .frame_stop_ok(frame_stop_ok),
    .exp_status   (exp_status),
    .exp_rdata    (exp_rdata),
    .n_value_err  (n_value_err),
    .n_frame_err  (n_frame_err),
    .n_proto_err  (n_proto_err),
    .n_done       (n_done)
  );

  task automatic read_vectors();
    int    fd;
    int    c, r, a, s, d;
    string line;
    fd = $fopen("verif/uart_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open verif/uart_vectors.txt, no commands to run");
    end else begin
      // comment lines do not scan as five fields
      while ($fgets(line, fd) != 0) begin
        if ($sscanf(line, "%h %h %d %d %h", c, r, a, s, d) == 5) begin
          vec_cmd.push_back(c[15:0]);
          vec_rsp.push_back(r[7:0]);
          vec_act.push_back(a[1:0]);
          vec_st.push_back(s[1:0]);
          vec_rdata.push_back(d[7:0]);
        end
      end
      $fclose(fd);
    end
  endtask

  // start, 8 data lsb first, parity, stop
  task automatic send_frame(input logic [7:0] data, input logic flip_par);
    logic [10:0] bits;
    bits = {1'b1, odd_parity(data) ^ flip_par, data, 1'b0};
    for (int i = 0; i < frame_bits; i++) begin
      rx <= bits[i];
      repeat (clks_per_bit) @(posedge clk);
    end
  endtask

  initial begin : host
    int n_vec;
    int total;
    cmd_req    = 1'b0;
    cmd_data   = '0;
    cur_cmd    = '0;
    cur_rsp    = '0;
    cur_act    = '0;
    exp_status = st_ok;
    exp_rdata  = '0;
    cmd_seq    = 0;
    read_vectors();
    n_vec = vec_cmd.size();
    limit = 10 + n_vec * (3 * frame_bits * clks_per_bit + rsp_timeout + 6 * clks_per_bit + 50);
    wait (rst_n);
    for (int k = 0; k < n_vec; k++) begin
      @(posedge clk);
      cur_cmd    <= vec_cmd[k];
      cur_rsp    <= vec_rsp[k];
      cur_act    <= vec_act[k];
      exp_status <= rsp_status_t'(vec_st[k]);
      exp_rdata  <= vec_rdata[k];
      cmd_seq    <= cmd_seq + 1;
      cmd_req    <= 1'b1;
      cmd_data   <= vec_cmd[k];
      do @(posedge clk); while (!cmd_ack);
      cmd_req <= 1'b0;
      do @(posedge clk); while (cmd_ack);
    end
    repeat (4) @(posedge clk);
    total = n_value_err + n_frame_err + n_proto_err;
    $display("errors: value %0d, frame %0d, protocol %0d; commands done %0d of %0d",
             n_value_err, n_frame_err, n_proto_err, n_done, n_vec);
    if (total == 0 && n_done == n_vec && n_vec > 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // device side, decodes tx at mid bit
  initial begin : tx_decoder
    logic [7:0] data;
    logic       par;
    logic       stp;
    int         hdr_seq;
    hdr_seq       = 0;
    frame_valid   = 1'b0;
    frame_byte    = '0;
    frame_par_ok  = 1'b0;
    frame_stop_ok = 1'b0;
    wait (rst_n);
    forever begin
      @(posedge clk);
      if (!tx) begin
        repeat (clks_per_bit / 2 - 1) @(posedge clk);
        for (int i = 0; i < 8; i++) begin
          repeat (clks_per_bit) @(posedge clk);
          data[i] = tx;
        end
        repeat (clks_per_bit) @(posedge clk);
        par = tx;
        repeat (clks_per_bit) @(posedge clk);
        stp = tx;
        frame_byte    <= data;
        frame_par_ok  <= ^{data, par};
        frame_stop_ok <= stp;
        frame_valid   <= 1'b1;
        // first frame of a read is the header
        if (cur_cmd[15] && hdr_seq != cmd_seq) begin
          hdr_seq = cmd_seq;
          -> rsp_go;
        end
        @(posedge clk);
        frame_valid <= 1'b0;
      end
    end
  end

  initial begin : responder
    int gap;
    rx = 1'b1;
    forever begin
      @(rsp_go);
      gap = 2 + int'($unsigned($random(seed)) % 5);
      repeat (gap * clks_per_bit) @(posedge clk);
      if (cur_act == 2'd0) begin
        send_frame(cur_rsp, 1'b0);
      end else if (cur_act == 2'd1) begin
        send_frame(cur_rsp, 1'b1);
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("run stopped at cycle %0d, the commands did not finish in time", cycles);
      $display("tests failed");
      $finish;
    end
  end

endmodule

// File: verif/uart_vectors.txt
# cmd  rsp  act  status  rdata   (hex, hex, dec, dec, hex)
# act 0 good frame, 1 flipped parity, 2 silent; status 0 ok, 1 bad frame, 2 timeout
1234 00 0 0 00
8500 a5 0 0 a5
0000 00 0 0 00
7fff 00 0 0 00
ff00 ff 0 0 ff
8a00 3c 1 1 00
9100 00 2 2 00
8000 00 0 0 00
2a5a 00 0 0 00
c300 5a 0 0 5a

// File: verilog/uart_cmd_pkg.sv
package uart_cmd_pkg;

  // bit periods per frame: start, 8 data, parity, stop
  localparam int frame_bits = 11;

  // host command word
  // [15] read flag, [14:8] register address, [7:0] write data
  typedef struct packed {
    logic       rd;
    logic [6:0] addr;
    logic [7:0] wdata;
  } cmd_t;

  typedef enum logic [1:0] {
    st_ok        = 2'd0,
    st_bad_frame = 2'd1,
    st_timeout   = 2'd2
  } rsp_status_t;

  // parity bit that makes data plus parity an odd count of ones
  function automatic logic odd_parity(input logic [7:0] data);
    logic par;
    par = ~^data;
    return par;
  endfunction

endpackage

// File: verilog/uart_cmd_seq.sv
module uart_cmd_seq
  import uart_cmd_pkg::*;
#(
  parameter int rsp_timeout = 400
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cmd_req,
  input  logic [15:0] cmd_data,
  output logic        cmd_ack,
  output logic [7:0]  rsp_data,
  output rsp_status_t rsp_status,
  output logic        byte_req,
  output logic [7:0]  byte_data,
  input  logic        byte_ack,
  input  logic        rx_valid,
  input  logic [7:0]  rx_data,
  input  logic        rx_bad,
  input  logic        rx_busy
);

  localparam int cw = $clog2(rsp_timeout + 1);

  typedef enum logic [2:0] {
    s_idle,
    s_hdr,
    s_data,
    s_wait,
    s_done,
    s_release
  } state_t;

  state_t        state;
  cmd_t          cmd_in;
  cmd_t          cmd_q;
  logic [cw-1:0] wait_cnt;
  logic          xfer_done;
  logic          timed_out;

  assign cmd_in = cmd_t'(cmd_data);

  // byte handshake back at rest after our request dropped
  assign xfer_done = !byte_req && !byte_ack;
  assign timed_out = wait_cnt == cw'(rsp_timeout);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= s_idle;
      byte_req <= 1'b0;
      cmd_ack  <= 1'b0;
      wait_cnt <= '0;
    end else begin
      case (state)
        s_idle: begin
          if (cmd_req) begin
            byte_req <= 1'b1;
            state    <= s_hdr;
          end
        end
        s_hdr: begin
          if (byte_req && byte_ack) begin
            byte_req <= 1'b0;
          end else if (xfer_done) begin
            if (cmd_q.rd) begin
              wait_cnt <= '0;
              state    <= s_wait;
            end else begin
              byte_req <= 1'b1;
              state    <= s_data;
            end
          end
        end
        s_data: begin
          if (byte_req && byte_ack) begin
            byte_req <= 1'b0;
          end else if (xfer_done) begin
            state <= s_done;
          end
        end
        s_wait: begin
          if (rx_valid || timed_out) begin
            state <= s_done;
          end else if (!rx_busy) begin
            // frame in progress holds the count
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        s_done: begin
          cmd_ack <= 1'b1;
          state   <= s_release;
        end
        s_release: begin
          if (!cmd_req) begin
            cmd_ack <= 1'b0;
            state   <= s_idle;
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == s_idle && cmd_req) begin
      cmd_q      <= cmd_in;
      byte_data  <= {cmd_in.rd, cmd_in.addr};
      rsp_data   <= '0;
      rsp_status <= st_ok;
    end else if (state == s_hdr && xfer_done && !cmd_q.rd) begin
      byte_data <= cmd_q.wdata;
    end else if (state == s_wait) begin
      if (rx_valid) begin
        rsp_data   <= rx_data;
        rsp_status <= rx_bad ? st_bad_frame : st_ok;
      end else if (timed_out) begin
        rsp_status <= st_timeout;
      end
    end
  end

  // ack only answers a pending host request
  a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cmd_ack) |-> $past(cmd_req));

  // transmitter drops its ack only once our request is gone
  a_ack_fall_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(byte_ack) |-> !$past(byte_req));

endmodule

// File: verilog/uart_cmd_top.sv
module uart_cmd_top
  import uart_cmd_pkg::*;
#(
  parameter int clks_per_bit = 16,
  parameter int rsp_timeout  = 400
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cmd_req,
  input  logic [15:0] cmd_data,
  output logic        cmd_ack,
  output logic [7:0]  rsp_data,
  output rsp_status_t rsp_status,
  output logic        tx,
  input  logic        rx
);

  logic       byte_req;
  logic [7:0] byte_data;
  logic       byte_ack;
  logic       rx_valid;
  logic [7:0] rx_data;
  logic       rx_bad;
  logic       rx_busy;

  uart_cmd_seq #(
    .rsp_timeout(rsp_timeout)
  ) i_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_req   (cmd_req),
    .cmd_data  (cmd_data),
    .cmd_ack   (cmd_ack),
    .rsp_data  (rsp_data),
    .rsp_status(rsp_status),
    .byte_req  (byte_req),
    .byte_data (byte_data),
    .byte_ack  (byte_ack),
    .rx_valid  (rx_valid),
    .rx_data   (rx_data),
    .rx_bad    (rx_bad),
    .rx_busy   (rx_busy)
  );

  uart_tx_frame #(
    .clks_per_bit(clks_per_bit)
  ) i_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .byte_req (byte_req),
    .byte_data(byte_data),
    .byte_ack (byte_ack),
    .tx       (tx)
  );

  uart_rx_frame #(
    .clks_per_bit(clks_per_bit)
  ) i_rx (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .rx_valid(rx_valid),
    .rx_data (rx_data),
    .rx_bad  (rx_bad),
    .rx_busy (rx_busy)
  );

endmodule

// File: verilog/uart_rx_frame.sv
module uart_rx_frame
  import uart_cmd_pkg::*;
#(
  parameter int clks_per_bit = 16
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  output logic       rx_valid,
  output logic [7:0] rx_data,
  output logic       rx_bad,
  output logic       rx_busy
);

  localparam int tw = $clog2(clks_per_bit);

  logic          rx_s1;
  logic          rx_s2;
  logic          rx_s3;
  logic          start_edge;
  logic          sample;
  logic [tw-1:0] bit_tmr;
  logic [3:0]    bit_idx;
  logic          par_bit;

  // two flops for metastability, third one for edge detect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
      rx_s3 <= 1'b1;
    end else begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
      rx_s3 <= rx_s2;
    end
  end

  assign start_edge = rx_s3 && !rx_s2;
  assign sample     = rx_busy && bit_tmr == '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_busy  <= 1'b0;
      rx_valid <= 1'b0;
      rx_bad   <= 1'b0;
      bit_tmr  <= '0;
      bit_idx  <= '0;
    end else begin
      rx_valid <= 1'b0;
      if (!rx_busy) begin
        if (start_edge) begin
          // first sample lands mid start bit
          rx_busy <= 1'b1;
          bit_tmr <= tw'(clks_per_bit / 2 - 1);
          bit_idx <= '0;
        end
      end else if (!sample) begin
        bit_tmr <= bit_tmr - 1'b1;
      end else begin
        bit_tmr <= tw'(clks_per_bit - 1);
        bit_idx <= bit_idx + 1'b1;
        if (bit_idx == 4'd0 && rx_s2) begin
          // start bit gone high again, glitch
          rx_busy <= 1'b0;
        end else if (bit_idx == 4'(frame_bits - 1)) begin
          rx_busy  <= 1'b0;
          rx_valid <= 1'b1;
          rx_bad   <= (par_bit != odd_parity(rx_data)) || !rx_s2;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sample) begin
      if (bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
        rx_data <= {rx_s2, rx_data[7:1]};
      end
      if (bit_idx == 4'd9) begin
        par_bit <= rx_s2;
      end
    end
  end

  a_valid_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    rx_valid |=> !rx_valid);

endmodule

// File: verilog/uart_tx_frame.sv
module uart_tx_frame
  import uart_cmd_pkg::*;
#(
  parameter int clks_per_bit = 16
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       byte_req,
  input  logic [7:0] byte_data,
  output logic       byte_ack,
  output logic       tx
);

  localparam int tw = $clog2(clks_per_bit);

  typedef enum logic [1:0] {
    t_idle,
    t_shift,
    t_ack
  } tstate_t;

  tstate_t               state;
  logic [tw-1:0]         bit_tmr;
  logic [3:0]            bit_cnt;
  logic [frame_bits-2:0] shreg;
  logic                  bit_end;

  assign bit_end = bit_tmr == tw'(clks_per_bit - 1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= t_idle;
      bit_tmr  <= '0;
      bit_cnt  <= '0;
      byte_ack <= 1'b0;
      tx       <= 1'b1;
    end else begin
      case (state)
        t_idle: begin
          if (byte_req) begin
            // start bit
            tx      <= 1'b0;
            bit_tmr <= '0;
            bit_cnt <= '0;
            state   <= t_shift;
          end
        end
        t_shift: begin
          if (bit_end) begin
            bit_tmr <= '0;
            if (bit_cnt == 4'(frame_bits - 1)) begin
              tx       <= 1'b1;
              byte_ack <= 1'b1;
              state    <= t_ack;
            end else begin
              tx      <= shreg[0];
              bit_cnt <= bit_cnt + 1'b1;
            end
          end else begin
            bit_tmr <= bit_tmr + 1'b1;
          end
        end
        t_ack: begin
          if (!byte_req) begin
            byte_ack <= 1'b0;
            state    <= t_idle;
          end
        end
        default: state <= t_idle;
      endcase
    end
  end

  // stop, parity, data lsb first
  always_ff @(posedge clk) begin
    if (state == t_idle && byte_req) begin
      shreg <= {1'b1, odd_parity(byte_data), byte_data};
    end else if (state == t_shift && bit_end) begin
      shreg <= shreg >> 1;
    end
  end

  a_idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
    state == t_idle |-> tx);

endmodule
